/* filelist.f */
rtl/uart_pkg.sv
rtl/uart_reg_if.sv
rtl/uart_axil_slave.sv
rtl/uart_bank.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
testbench/uart_tb.sv

/* rtl/uart_axil_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_axil_slave (
  input logic clock,
  input logic reset,
  // Write address
  input logic [4:0] awaddr,
  input logic awvalid,
  output logic awready,
  // Write data
  input uart_pkg::data_t wdata,
  input logic wvalid,
  output logic wready,
  // Write response
  output logic [1:0] bresp,
  output logic bvalid,
  input logic bready,
  // Read address
  input logic [4:0] araddr,
  input logic arvalid,
  output logic arready,
  // Read data
  output uart_pkg::data_t rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input logic rready,
  uart_reg_if.front bus
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_DATA
  } state_t;

  state_t state;
  logic wr_accept;
  logic rd_accept;

  // Writes win when both channels are pending
  assign wr_accept = (state == IDLE) && awvalid && wvalid;
  assign rd_accept = (state == IDLE) && !wr_accept && arvalid;

  assign awready = wr_accept;
  assign wready = wr_accept;
  assign arready = rd_accept;

  // Single-cycle register access
  assign bus.wr_en = wr_accept;
  assign bus.rd_en = rd_accept;
  assign bus.index = wr_accept ? awaddr[4:2] : araddr[4:2];
  assign bus.wr_data = wdata;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (wr_accept) begin
            state <= WRITE_RESP;
          end else if (rd_accept) begin
            state <= READ_DATA;
          end
        end
        WRITE_RESP: begin
          if (bready) begin
            state <= IDLE;
          end
        end
        READ_DATA: begin
          if (rready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign bvalid = (state == WRITE_RESP);
  assign bresp = 2'b00;

  // Bank holds the read word until the next read
  assign rvalid = (state == READ_DATA);
  assign rdata = bus.rd_data;
  assign rresp = 2'b00;

endmodule

`default_nettype wire

/* rtl/uart_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_bank #(
  parameter int FIFO_DEPTH = 8,
  parameter int unsigned CLOCK_FREQ_HZ = 10000000
) (
  input logic clock,
  input logic reset,
  uart_reg_if.bank bus,
  // TX FIFO
  output logic tx_push,
  output uart_pkg::byte_t tx_data,
  input logic tx_full,
  input logic [$clog2(FIFO_DEPTH):0] tx_count,
  // RX FIFO
  output logic rx_pop,
  input uart_pkg::byte_t rx_data,
  input logic rx_empty,
  input logic [$clog2(FIFO_DEPTH):0] rx_count,
  // PHY control
  output logic txen,
  output logic nstop,
  output logic rxen,
  output uart_pkg::divisor_t div,
  output logic irq
);
  import uart_pkg::*;

  localparam divisor_t DIV_RESET = default_divisor(CLOCK_FREQ_HZ);

  logic [2:0] txcnt;
  logic [2:0] rxcnt;
  logic [1:0] ie;
  logic tx_pending;
  logic rx_pending;
  logic wr_txdata;
  data_t read_word;

  assign wr_txdata = bus.wr_en && (bus.index == TXDATA_IDX);

  // Full FIFO drops the byte
  assign tx_push = wr_txdata && !tx_full;
  assign tx_data = bus.wr_data[7:0];
  assign rx_pop = bus.rd_en && (bus.index == RXDATA_IDX) && !rx_empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      txen <= 1'b0;
      nstop <= 1'b0;
      txcnt <= 3'd0;
      rxen <= 1'b0;
      rxcnt <= 3'd0;
      ie <= 2'b00;
      div <= DIV_RESET;
    end else if (bus.wr_en) begin
      case (bus.index)
        TXCTRL_IDX: begin
          txen <= bus.wr_data[0];
          nstop <= bus.wr_data[1];
          txcnt <= bus.wr_data[18:16];
        end
        RXCTRL_IDX: begin
          rxen <= bus.wr_data[0];
          rxcnt <= bus.wr_data[18:16];
        end
        IE_IDX: ie <= bus.wr_data[1:0];
        DIV_IDX: div <= bus.wr_data[15:0];
        default: ;
      endcase
    end
  end

  // Watermarks
  assign tx_pending = 32'(tx_count) < 32'(txcnt);
  assign rx_pending = 32'(rx_count) > 32'(rxcnt);

  always_comb begin
    case (bus.index)
      TXDATA_IDX: read_word = {tx_full, 31'b0};
      // rx_empty is taken before the pop lands
      RXDATA_IDX: read_word = {rx_empty, 23'b0, rx_data};
      TXCTRL_IDX: read_word = {13'b0, txcnt, 14'b0, nstop, txen};
      RXCTRL_IDX: read_word = {13'b0, rxcnt, 15'b0, rxen};
      IE_IDX: read_word = {30'b0, ie};
      IP_IDX: read_word = {30'b0, rx_pending, tx_pending};
      DIV_IDX: read_word = {16'b0, div};
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bus.rd_data <= '0;
    end else if (bus.rd_en) begin
      bus.rd_data <= read_word;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq <= 1'b0;
    end else begin
      irq <= (tx_pending && ie[0]) || (rx_pending && ie[1]);
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter int DEPTH = 8
) (
  input logic clock,
  input logic reset,
  input logic push,
  input uart_pkg::byte_t wr_data,
  input logic pop,
  output uart_pkg::byte_t rd_data,
  output logic full,
  output logic empty,
  output logic [$clog2(DEPTH):0] count
);
  import uart_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  byte_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign rd_data = mem[rd_ptr];
  assign full = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

endmodule

`default_nettype wire

/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  typedef logic [31:0] data_t;
  typedef logic [7:0] byte_t;
  typedef logic [2:0] reg_index_t;
  typedef logic [15:0] divisor_t;

  // Word index of each register, address bits 4:2
  localparam reg_index_t TXDATA_IDX = 3'd0;
  localparam reg_index_t RXDATA_IDX = 3'd1;
  localparam reg_index_t TXCTRL_IDX = 3'd2;
  localparam reg_index_t RXCTRL_IDX = 3'd3;
  localparam reg_index_t IE_IDX = 3'd4;
  localparam reg_index_t IP_IDX = 3'd5;
  localparam reg_index_t DIV_IDX = 3'd6;

  localparam int unsigned DEFAULT_BAUD = 115200;

  // Divisor for the default baud rate, one bit lasts divisor + 1 clocks
  function automatic divisor_t default_divisor(input int unsigned clock_freq_hz);
    int unsigned ratio;
    ratio = clock_freq_hz / DEFAULT_BAUD;
    return divisor_t'(ratio - 1);
  endfunction

endpackage

`default_nettype wire

/* rtl/uart_reg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface uart_reg_if;
  import uart_pkg::*;

  logic wr_en;
  logic rd_en;
  reg_index_t index;
  data_t wr_data;
  data_t rd_data;

  // AXI side
  modport front (
    output wr_en,
    output rd_en,
    output index,
    output wr_data,
    input rd_data
  );

  // Register bank side
  modport bank (
    input wr_en,
    input rd_en,
    input index,
    input wr_data,
    output rd_data
  );

endinterface

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input logic clock,
  input logic reset,
  input logic rxen,
  input uart_pkg::divisor_t div,
  input logic rxd,
  output logic push,
  output uart_pkg::byte_t data,
  input logic full
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_t;

  state_t state;
  divisor_t baud_cnt;
  logic [2:0] bit_cnt;
  logic rxd_meta;
  logic rxd_sync;
  logic rxd_prev;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IDLE;
      baud_cnt <= '0;
      bit_cnt <= '0;
      data <= '0;
      push <= 1'b0;
    end else begin
      push <= 1'b0;
      if (state == IDLE) begin
        // Falling edge marks a start bit, wait half a bit
        if (rxen && rxd_prev && !rxd_sync) begin
          state <= START;
          baud_cnt <= div >> 1;
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= div;
        case (state)
          START: begin
            state <= rxd_sync ? IDLE : DATA;
            bit_cnt <= '0;
          end
          DATA: begin
            data <= {rxd_sync, data[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= STOP;
            end
          end
          default: begin
            push <= rxd_sync && !full;
            state <= IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
  parameter int FIFO_DEPTH = 8,
  parameter int unsigned CLOCK_FREQ_HZ = 10000000
) (
  input logic clock,
  input logic reset,
  input logic [4:0] awaddr,
  input logic awvalid,
  output logic awready,
  input uart_pkg::data_t wdata,
  input logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input logic bready,
  input logic [4:0] araddr,
  input logic arvalid,
  output logic arready,
  output uart_pkg::data_t rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input logic rready,
  output logic txd,
  input logic rxd,
  output logic irq
);
  import uart_pkg::*;

  logic tx_push;
  logic tx_pop;
  logic tx_full;
  logic tx_empty;
  byte_t tx_wr_data;
  byte_t tx_rd_data;
  logic [$clog2(FIFO_DEPTH):0] tx_count;
  logic rx_push;
  logic rx_pop;
  logic rx_full;
  logic rx_empty;
  byte_t rx_wr_data;
  byte_t rx_rd_data;
  logic [$clog2(FIFO_DEPTH):0] rx_count;
  logic txen;
  logic nstop;
  logic rxen;
  divisor_t div;

  uart_reg_if bus_i ();

  uart_axil_slave axil_i (
    .clock(clock), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .bus(bus_i.front)
  );

  uart_bank #(.FIFO_DEPTH(FIFO_DEPTH), .CLOCK_FREQ_HZ(CLOCK_FREQ_HZ)) bank_i (
    .clock(clock), .reset(reset), .bus(bus_i.bank),
    .tx_push(tx_push), .tx_data(tx_wr_data), .tx_full(tx_full), .tx_count(tx_count),
    .rx_pop(rx_pop), .rx_data(rx_rd_data), .rx_empty(rx_empty), .rx_count(rx_count),
    .txen(txen), .nstop(nstop), .rxen(rxen), .div(div), .irq(irq)
  );

  uart_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo_i (
    .clock(clock), .reset(reset),
    .push(tx_push), .wr_data(tx_wr_data), .pop(tx_pop), .rd_data(tx_rd_data),
    .full(tx_full), .empty(tx_empty), .count(tx_count)
  );

  uart_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo_i (
    .clock(clock), .reset(reset),
    .push(rx_push), .wr_data(rx_wr_data), .pop(rx_pop), .rd_data(rx_rd_data),
    .full(rx_full), .empty(rx_empty), .count(rx_count)
  );

  uart_tx tx_i (
    .clock(clock), .reset(reset), .txen(txen), .nstop(nstop), .div(div),
    .empty(tx_empty), .pop(tx_pop), .data(tx_rd_data), .txd(txd)
  );

  uart_rx rx_i (
    .clock(clock), .reset(reset), .rxen(rxen), .div(div), .rxd(rxd),
    .push(rx_push), .data(rx_wr_data), .full(rx_full)
  );

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input logic clock,
  input logic reset,
  input logic txen,
  input logic nstop,
  input uart_pkg::divisor_t div,
  input logic empty,
  output logic pop,
  input uart_pkg::byte_t data,
  output logic txd
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_t;

  state_t state;
  divisor_t baud_cnt;
  byte_t shift;
  logic [2:0] bit_cnt;
  logic bit_done;

  assign pop = (state == IDLE) && txen && !empty;
  assign bit_done = (baud_cnt == '0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IDLE;
      baud_cnt <= '0;
      shift <= '0;
      bit_cnt <= '0;
      txd <= 1'b1;
    end else if (state == IDLE) begin
      if (pop) begin
        state <= START;
        shift <= data;
        baud_cnt <= div;
        txd <= 1'b0;
      end
    end else if (!bit_done) begin
      baud_cnt <= baud_cnt - 1'b1;
    end else begin
      baud_cnt <= div;
      case (state)
        START: begin
          state <= DATA;
          bit_cnt <= '0;
          txd <= shift[0];
          shift <= shift >> 1;
        end
        DATA: begin
          if (bit_cnt == 3'd7) begin
            // Remaining stop bits minus one
            state <= STOP;
            bit_cnt <= {2'b00, nstop};
            txd <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            txd <= shift[0];
            shift <= shift >> 1;
          end
        end
        default: begin
          if (bit_cnt == '0) begin
            state <= IDLE;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module uart_tb \
  -f filelist.f -o uart_sim \
  && ./obj_dir/uart_sim > sim.log 2>&1 \
  || echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && exit 0 || exit 1

/* testbench/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
  import uart_pkg::*;

  localparam int EXPECTED_DIV = 10000000 / 115200 - 1;
  // div is set to 3 for the serial tests
  localparam int BIT_CYCLES = 4;
  localparam int WAIT_LIMIT = 4000;

  logic clock;
  logic reset;
  logic [4:0] awaddr;
  logic awvalid;
  logic awready;
  data_t wdata;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [4:0] araddr;
  logic arvalid;
  logic arready;
  data_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic txd;
  logic rxd;
  logic irq;
  logic [31:0] random_state = 32'h6c39efce;

  // Serial loopback
  assign rxd = txd;

  uart_top dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    abort_run();
  endtask

  assert property (@(posedge clock) disable iff (reset) (!bvalid || bresp == 2'b00))
    else report_mismatch("write response is not OKAY");
  assert property (@(posedge clock) disable iff (reset) (!rvalid || rresp == 2'b00))
    else report_mismatch("read response is not OKAY");

  function automatic logic [31:0] next_random();
    random_state = random_state * 32'd1664525 + 32'd1013904223;
    return random_state;
  endfunction

  task automatic check_value(input data_t actual, input data_t expected, input string what);
    assert (actual == expected)
      else report_mismatch($sformatf("%s read %h, expected %h", what, actual, expected));
  endtask

  task automatic write_reg(input reg_index_t idx, input data_t value);
    int cycles;
    @(posedge clock);
    awaddr <= {idx, 2'b00};
    awvalid <= 1'b1;
    wdata <= value;
    wvalid <= 1'b1;
    bready <= 1'b1;
    cycles = 0;
    @(negedge clock);
    while (!(awready && wready)) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("awready and wready");
      @(negedge clock);
    end
    @(posedge clock);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    cycles = 0;
    @(negedge clock);
    while (!bvalid) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("bvalid");
      @(negedge clock);
    end
    @(posedge clock);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input reg_index_t idx, output data_t data);
    int cycles;
    @(posedge clock);
    araddr <= {idx, 2'b00};
    arvalid <= 1'b1;
    rready <= 1'b1;
    cycles = 0;
    @(negedge clock);
    while (!arready) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("arready");
      @(negedge clock);
    end
    @(posedge clock);
    arvalid <= 1'b0;
    cycles = 0;
    @(negedge clock);
    while (!rvalid) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("rvalid");
      @(negedge clock);
    end
    data = rdata;
    @(posedge clock);
    rready <= 1'b0;
  endtask

  task automatic check_readback(input reg_index_t idx, input data_t mask, input string name);
    data_t written;
    data_t word;
    written = next_random();
    write_reg(idx, written);
    read_reg(idx, word);
    check_value(word, written & mask, name);
  endtask

  task automatic wait_for_irq(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (irq !== level) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout($sformatf("irq to become %0b", level));
      @(negedge clock);
    end
  endtask

  task automatic wait_line_idle(input int bits);
    int cycles;
    int high;
    cycles = 0;
    high = 0;
    while (high < bits * BIT_CYCLES) begin
      @(negedge clock);
      cycles++;
      high = txd ? high + 1 : 0;
      if (cycles > WAIT_LIMIT) report_timeout("txd to go idle");
    end
  endtask

  // Mid-bit check of one frame
  // idle counts the high cycles before its start bit
  task automatic check_frame(input byte_t expected, input int stops, output int idle);
    idle = 0;
    @(negedge clock);
    while (txd) begin
      idle++;
      if (idle > WAIT_LIMIT) report_timeout("a start bit on txd");
      @(negedge clock);
    end
    for (int k = 1; k < BIT_CYCLES; k++) begin
      @(negedge clock);
      assert (!txd) else report_mismatch("start bit shorter than one bit period");
    end
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < BIT_CYCLES; k++) begin
        @(negedge clock);
        if (k == BIT_CYCLES / 2) begin
          assert (txd == expected[i])
            else report_mismatch($sformatf("bit %0d of frame %h on txd", i, expected));
        end
      end
    end
    for (int k = 0; k < stops * BIT_CYCLES; k++) begin
      @(negedge clock);
      assert (txd) else report_mismatch("stop bit low on txd");
    end
  endtask

  task automatic expect_received(input byte_t expected [$]);
    data_t word;
    foreach (expected[i]) begin
      read_reg(RXDATA_IDX, word);
      check_value(word, {24'b0, expected[i]}, "rxdata");
    end
    read_reg(RXDATA_IDX, word);
    assert (word[31]) else report_mismatch("rxdata not empty after the expected bytes");
  endtask

  initial begin
    data_t word;
    byte_t b;
    byte_t pair [2];
    byte_t sent [$];
    int idle;
    $timeformat(-9, 0, " ns", 0);
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    read_reg(DIV_IDX, word);
    check_value(word, 32'(EXPECTED_DIV), "div after reset");
    read_reg(TXCTRL_IDX, word);
    check_value(word, '0, "txctrl after reset");
    read_reg(RXCTRL_IDX, word);
    check_value(word, '0, "rxctrl after reset");
    read_reg(IE_IDX, word);
    check_value(word, '0, "ie after reset");
    read_reg(IP_IDX, word);
    check_value(word, '0, "ip after reset");
    read_reg(RXDATA_IDX, word);
    assert (word[31]) else report_mismatch("rxdata empty flag clear after reset");
    @(negedge clock);
    assert (txd && !irq) else report_mismatch("txd low or irq high after reset");

    for (int n = 0; n < 2; n++) begin
      check_readback(TXCTRL_IDX, 32'h0007_0003, "txctrl");
      check_readback(RXCTRL_IDX, 32'h0007_0001, "rxctrl");
      check_readback(IE_IDX, 32'h0000_0003, "ie");
      check_readback(DIV_IDX, 32'h0000_ffff, "div");
    end
    write_reg(IE_IDX, '0);
    write_reg(RXCTRL_IDX, '0);
    write_reg(TXCTRL_IDX, '0);
    write_reg(DIV_IDX, 32'(BIT_CYCLES - 1));

    // Two back-to-back frames
    // Gap between them shows the stop length
    for (int stops = 1; stops <= 2; stops++) begin
      write_reg(TXCTRL_IDX, '0);
      pair[0] = byte_t'(next_random() >> 24);
      pair[1] = byte_t'(next_random() >> 24);
      write_reg(TXDATA_IDX, {24'b0, pair[0]});
      write_reg(TXDATA_IDX, {24'b0, pair[1]});
      write_reg(TXCTRL_IDX, 32'((stops - 1) << 1) | 32'h1);
      check_frame(pair[0], stops, idle);
      check_frame(pair[1], stops, idle);
      assert (idle < BIT_CYCLES) else report_mismatch("stop period longer than configured");
      wait_line_idle(2);
    end

    write_reg(TXCTRL_IDX, 32'h1);
    write_reg(RXCTRL_IDX, 32'h1);
    for (int i = 0; i < 5; i++) begin
      b = byte_t'(next_random() >> 24);
      sent.push_back(b);
      write_reg(TXDATA_IDX, {24'b0, b});
    end
    wait_line_idle(12);
    expect_received(sent);

    // RX watermark at one byte
    sent.delete();
    write_reg(RXCTRL_IDX, 32'h0001_0001);
    write_reg(IE_IDX, 32'h2);
    b = byte_t'(next_random() >> 24);
    sent.push_back(b);
    write_reg(TXDATA_IDX, {24'b0, b});
    wait_line_idle(12);
    assert (!irq) else report_mismatch("irq high with only one byte received");
    b = byte_t'(next_random() >> 24);
    sent.push_back(b);
    write_reg(TXDATA_IDX, {24'b0, b});
    wait_for_irq(1'b1);
    read_reg(IP_IDX, word);
    check_value(word, 32'h2, "ip with two bytes received");
    wait_line_idle(2);
    expect_received(sent);
    wait_for_irq(1'b0);

    // TX watermark at one byte
    write_reg(IE_IDX, 32'h1);
    write_reg(RXCTRL_IDX, '0);
    write_reg(TXCTRL_IDX, 32'h0001_0001);
    wait_for_irq(1'b1);
    read_reg(IP_IDX, word);
    check_value(word, 32'h1, "ip with empty TX FIFO");
    write_reg(TXCTRL_IDX, 32'h0001_0000);
    write_reg(TXDATA_IDX, 32'h55);
    wait_for_irq(1'b0);
    write_reg(TXCTRL_IDX, 32'h0001_0001);
    wait_for_irq(1'b1);
    write_reg(IE_IDX, '0);
    wait_line_idle(12);

    sent.delete();
    write_reg(TXCTRL_IDX, '0);
    write_reg(RXCTRL_IDX, 32'h1);
    for (int i = 0; i < 8; i++) begin
      b = byte_t'(next_random() >> 24);
      sent.push_back(b);
      write_reg(TXDATA_IDX, {24'b0, b});
    end
    read_reg(TXDATA_IDX, word);
    assert (word[31]) else report_mismatch("txdata full flag clear after eight writes");
    write_reg(TXDATA_IDX, {24'b0, ~sent[0]});
    write_reg(TXCTRL_IDX, 32'h1);
    foreach (sent[i]) begin
      check_frame(sent[i], 1, idle);
    end
    // Ninth byte must not show up
    for (int k = 0; k < 12 * BIT_CYCLES; k++) begin
      @(negedge clock);
      assert (txd) else report_mismatch("extra frame on txd after a full TX FIFO");
    end
    expect_received(sent);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
